// ==== spi_reg_link.f ====
verilog/spi_link_pkg.sv
verilog/sclk_gen.sv
verilog/spi_master.sv
verilog/spi_target.sv
verilog/spi_reg_link.sv
sim/spi_reg_link_tb.sv

// ==== Bender.yml ====
package:
  name: spi_reg_link

sources:
  - files:
      - verilog/spi_link_pkg.sv
      - verilog/sclk_gen.sv
      - verilog/spi_master.sv
      - verilog/spi_target.sv
      - verilog/spi_reg_link.sv
  - target: simulation
    files:
      - sim/spi_reg_link_tb.sv

// ==== sim/spi_reg_link_tb.sv ====
module spi_reg_link_tb
  import spi_link_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int WAIT_LIMIT = 400;  // Cycles allowed for one transfer
  localparam int MIX_COUNT  = 24;

  logic  clk;
  logic  rst_n;
  cmd_t  cmd_in;
  logic  cmd_vld;
  logic  cmd_rdy;
  logic  read_vld;
  data_t read_data;
  regs_t cfg_regs;
  logic  sclk;
  logic  cs;
  logic  mosi;
  logic  miso;

  int          errors = 0;
  int          rise_cnt = 0;
  int          vld_cnt = 0;
  int          cs_marks[$];  // sclk rise count at each cs rise
  cmd_t        mosi_seen;    // mosi at each sclk rise
  data_t       miso_seen;
  logic [31:0] rng;
  data_t       model [NUM_REGS];

  spi_reg_link u_spi_reg_link (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_in    (cmd_in),
    .cmd_vld   (cmd_vld),
    .cmd_rdy   (cmd_rdy),
    .read_vld  (read_vld),
    .read_data (read_data),
    .cfg_regs  (cfg_regs),
    .sclk      (sclk),
    .cs        (cs),
    .mosi      (mosi),
    .miso      (miso)
  );

  initial
  begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  always @(posedge sclk)
  begin
    rise_cnt++;
    mosi_seen = {mosi_seen[CMD_BITS-2:0], mosi};
    miso_seen = {miso_seen[DATA_BITS-2:0], miso};
  end

  always @(posedge cs)
    cs_marks.push_back(rise_cnt);

  always @(posedge clk)
  begin
    if (read_vld === 1'b1)
      vld_cnt++;
  end

  // Ends a run that has stalled
  initial
  begin
    #60us;  // About 60 transactions of up to 200 cycles
    $display("Watchdog expired: simulation did not finish within 60 us");
    $display("Error count: %0d", errors);
    $display("ERRORS FOUND");
    $finish;
  end

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic regs_t model_regs();
    regs_t r;
    for (int i = 0; i < NUM_REGS; i++)
      r[i*DATA_BITS +: DATA_BITS] = model[i];
    return r;
  endfunction

  task automatic check_eq(input string name, input logic [63:0] got, input logic [63:0] exp);
    assert (got === exp)
    else
    begin
      errors++;
      $display("Fail %s: got %h expected %h", name, got, exp);
    end
  endtask

  task automatic start_frame(input cmd_t c);
    rise_cnt = 0;
    vld_cnt  = 0;
    cs_marks.delete();
    @(posedge clk);
    cmd_in  <= c;
    cmd_vld <= 1'b1;
    @(posedge clk);
    cmd_vld <= 1'b0;
    @(negedge clk);
    check_eq("cmd_rdy after accept", cmd_rdy, 1'b0);
  endtask

  // Extra strobe while the DUT is busy
  task automatic inject_stray(input cmd_t c);
    repeat (6) @(posedge clk);
    cmd_in  <= c;
    cmd_vld <= 1'b1;
    @(posedge clk);
    cmd_vld <= 1'b0;
  endtask

  task automatic wait_ready(output bit ok);
    ok = 1'b0;
    for (int n = 0; n < WAIT_LIMIT && !ok; n++)
    begin
      @(negedge clk);
      ok = cmd_rdy;
    end
    assert (ok)
    else
    begin
      errors++;
      $display("Timed out waiting for cmd_rdy to return high");
    end
  endtask

  task automatic wait_read(output bit ok);
    ok = 1'b0;
    for (int n = 0; n < WAIT_LIMIT && !ok; n++)
    begin
      @(negedge clk);
      ok = read_vld;
    end
    assert (ok)
    else
    begin
      errors++;
      $display("Timed out waiting for the read_vld strobe");
    end
  endtask

  task automatic write_reg(input addr_t a, input data_t d, input bit stray);
    cmd_t c;
    bit   ok;
    c = {1'b1, a, d};
    start_frame(c);
    if (stray)
      inject_stray(~c);  // Read of another address
    wait_ready(ok);
    model[a] = d;
    check_eq("cfg_regs", cfg_regs, model_regs());
    repeat (3) @(negedge clk);
    check_eq("read_vld pulses", vld_cnt, 0);
    check_eq("cs rises", cs_marks.size(), 1);
    check_eq("sclk rises", rise_cnt, CMD_BITS);
    check_eq("mosi", mosi_seen, c);
    if (cs_marks.size() > 0)
      check_eq("sclk rises before cs high", cs_marks[0], CMD_BITS);
  endtask

  task automatic read_reg(input addr_t a, input bit stray);
    cmd_t c;
    bit   ok;
    c = {1'b0, a, 8'h00};
    start_frame(c);
    if (stray)
      inject_stray(~c);  // Write to another address
    wait_read(ok);
    if (ok)
    begin
      check_eq("read_data", read_data, model[a]);
      check_eq("cmd_rdy with read_vld", cmd_rdy, 1'b1);
    end
    repeat (3) @(negedge clk);
    check_eq("read_vld pulses", vld_cnt, 1);
    check_eq("cs rises", cs_marks.size(), 2);
    check_eq("sclk rises", rise_cnt, HDR_BITS + DATA_BITS);
    check_eq("mosi", mosi_seen[CMD_BITS-1 -: HDR_BITS], {1'b0, a});
    check_eq("miso", miso_seen, model[a]);
    if (cs_marks.size() > 0)
      check_eq("sclk rises in header", cs_marks[0], HDR_BITS);
    check_eq("cfg_regs", cfg_regs, model_regs());
  endtask

  task automatic test_reset_state();
    check_eq("cmd_rdy", cmd_rdy, 1'b1);
    check_eq("read_vld", read_vld, 1'b0);
    check_eq("cs", cs, 1'b1);
    check_eq("sclk", sclk, 1'b0);
    check_eq("mosi", mosi, 1'b0);
    check_eq("miso", miso, 1'b0);
    check_eq("cfg_regs", cfg_regs, '0);
    for (int a = 0; a < NUM_REGS; a++)
      read_reg(addr_t'(a), 1'b0);
  endtask

  task automatic test_write_all();
    for (int a = 0; a < NUM_REGS; a++)
    begin
      rng = xorshift(rng);
      write_reg(addr_t'(a), rng[7:0], 1'b0);
    end
  endtask

  task automatic test_read_all();
    for (int a = 0; a < NUM_REGS; a++)
      read_reg(addr_t'(a), 1'b0);
  endtask

  task automatic test_random_mix();
    repeat (12)
    begin
      rng = xorshift(rng);
      write_reg(rng[10:8], rng[7:0], 1'b0);
    end
    repeat (MIX_COUNT)
    begin
      rng = xorshift(rng);
      if (rng[16])
        write_reg(rng[10:8], rng[7:0], 1'b0);
      else
        read_reg(rng[10:8], 1'b0);
    end
  endtask

  task automatic test_ignored_strobe();
    write_reg(3'd2, 8'h5a, 1'b1);
    read_reg(3'd5, 1'b1);
    read_reg(3'd2, 1'b0);
  endtask

  initial
  begin
    rst_n   = 1'b0;
    cmd_in  = '0;
    cmd_vld = 1'b0;
    rng     = 32'h40f0_b2ec;
    for (int i = 0; i < NUM_REGS; i++)
      model[i] = '0;
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);

    test_reset_state();
    test_write_all();
    test_read_all();
    test_random_mix();
    test_ignored_strobe();

    $display("Error count: %0d", errors);
    if (errors == 0)
      $display("NO ERRORS");
    else
      $display("ERRORS FOUND");
    $finish;
  end

endmodule

// ==== verilog/spi_reg_link.sv ====
module spi_reg_link
  import spi_link_pkg::*;
(
  input  logic  clk,
  input  logic  rst_n,
  input  cmd_t  cmd_in,
  input  logic  cmd_vld,
  output logic  cmd_rdy,
  output logic  read_vld,
  output data_t read_data,
  output regs_t cfg_regs,
  output logic  sclk,
  output logic  cs,
  output logic  mosi,
  output logic  miso
);

  logic sclk_en;
  logic sclk_rise;
  logic sclk_fall;

  spi_master u_master (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_in    (cmd_in),
    .cmd_vld   (cmd_vld),
    .cmd_rdy   (cmd_rdy),
    .sclk_rise (sclk_rise),
    .sclk_fall (sclk_fall),
    .sclk_en   (sclk_en),
    .cs        (cs),
    .mosi      (mosi),
    .miso      (miso),
    .read_vld  (read_vld),
    .read_data (read_data)
  );

  sclk_gen u_sclk_gen (
    .clk       (clk),
    .rst_n     (rst_n),
    .sclk_en   (sclk_en),
    .sclk      (sclk),
    .sclk_rise (sclk_rise),
    .sclk_fall (sclk_fall)
  );

  spi_target u_target (
    .clk      (clk),
    .rst_n    (rst_n),
    .sclk     (sclk),
    .cs       (cs),
    .mosi     (mosi),
    .miso     (miso),
    .cfg_regs (cfg_regs)
  );

endmodule

// ==== verilog/spi_target.sv ====
module spi_target
  import spi_link_pkg::*;
(
  input  logic  clk,
  input  logic  rst_n,
  input  logic  sclk,
  input  logic  cs,
  input  logic  mosi,
  output logic  miso,
  output regs_t cfg_regs
);

  logic [2:0]          sclk_q;
  logic [2:0]          cs_q;
  logic                sclk_rise;
  logic                sclk_fall;
  logic                cs_rise;
  logic                cs_fall;
  logic                collect;
  logic [CMD_BITS-2:0] rx_sh;
  cmd_t                frame;
  bit_cnt_t            bit_cnt;
  logic                rd_pend;
  logic                rd_active;
  addr_t               rd_addr;
  data_t               tx_sh;
  data_t               regs [NUM_REGS];

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      sclk_q <= '0;
      cs_q   <= '1;  // Idle high, no false cs fall
    end
    else
    begin
      sclk_q <= {sclk_q[1:0], sclk};
      cs_q   <= {cs_q[1:0], cs};
    end
  end

  assign sclk_rise = sclk_q[1] & ~sclk_q[2];
  assign sclk_fall = ~sclk_q[1] & sclk_q[2];
  assign cs_rise   = cs_q[1] & ~cs_q[2];
  assign cs_fall   = ~cs_q[1] & cs_q[2];

  // Header and write bits only, never during read data
  assign collect = ~cs_q[1] && !rd_active && sclk_rise && (bit_cnt < bit_cnt_t'(CMD_BITS));
  assign frame   = {rx_sh, mosi};  // Word including the bit being sampled

  always_ff @(posedge clk)
  begin
    if (collect)
      rx_sh <= frame[CMD_BITS-2:0];
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      bit_cnt   <= '0;
      rd_pend   <= 1'b0;
      rd_active <= 1'b0;
      rd_addr   <= '0;
      tx_sh     <= '0;
      for (int i = 0; i < NUM_REGS; i++)
        regs[i] <= '0;
    end
    else if (cs_rise)
    begin
      bit_cnt   <= '0;    // Partial frame dropped, rd_pend kept
      rd_active <= 1'b0;
      tx_sh     <= '0;
    end
    else if (cs_fall && rd_pend)
    begin
      rd_pend   <= 1'b0;
      rd_active <= 1'b1;
      tx_sh     <= regs[rd_addr];
    end
    else if (rd_active && sclk_fall)
      tx_sh <= {tx_sh[DATA_BITS-2:0], 1'b0};
    else if (collect)
    begin
      bit_cnt <= bit_cnt + 1'b1;
      if (bit_cnt == bit_cnt_t'(HDR_BITS - 1) && !frame[HDR_BITS-1])
      begin
        rd_pend <= 1'b1;
        rd_addr <= frame[HDR_BITS-2:0];
      end
      if (bit_cnt == bit_cnt_t'(CMD_BITS - 1) && frame[WR_FLAG_BIT])
        regs[frame[WR_FLAG_BIT-1 -: ADDR_BITS]] <= frame[DATA_BITS-1:0];
    end
  end

  assign miso = tx_sh[DATA_BITS-1];

  always_comb
  begin
    for (int i = 0; i < NUM_REGS; i++)
      cfg_regs[i*DATA_BITS +: DATA_BITS] = regs[i];
  end

endmodule

// ==== verilog/spi_master.sv ====
module spi_master
  import spi_link_pkg::*;
(
  input  logic  clk,
  input  logic  rst_n,
  input  cmd_t  cmd_in,
  input  logic  cmd_vld,
  output logic  cmd_rdy,
  input  logic  sclk_rise,
  input  logic  sclk_fall,
  output logic  sclk_en,
  output logic  cs,
  output logic  mosi,
  input  logic  miso,
  output logic  read_vld,
  output data_t read_data
);

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_WR_SHIFT,
    ST_WR_FIN,
    ST_HDR_SHIFT,
    ST_GAP,
    ST_RD_SHIFT,
    ST_RD_FIN
  } state_t;

  state_t   state;
  bit_cnt_t bit_cnt;
  bit_cnt_t last_bit;
  gap_cnt_t gap_cnt;
  cmd_t     tx_sh;
  data_t    rx_sh;
  logic     accept;
  logic     shifting;

  assign accept   = cmd_vld && cmd_rdy;
  assign shifting = (state == ST_WR_SHIFT) || (state == ST_HDR_SHIFT);
  assign last_bit = (state == ST_WR_SHIFT) ? bit_cnt_t'(CMD_BITS - 1)
                                           : bit_cnt_t'(HDR_BITS - 1);

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state    <= ST_IDLE;
      cmd_rdy  <= 1'b1;
      sclk_en  <= 1'b0;
      cs       <= 1'b1;
      mosi     <= 1'b0;
      read_vld <= 1'b0;
      bit_cnt  <= '0;
      gap_cnt  <= '0;
    end
    else
    begin
      read_vld <= 1'b0;
      case (state)
        ST_IDLE:
        begin
          if (accept)
          begin
            cmd_rdy <= 1'b0;
            cs      <= 1'b0;
            sclk_en <= 1'b1;
            mosi    <= cmd_in[WR_FLAG_BIT];  // MSB ready before first rise
            bit_cnt <= '0;
            state   <= cmd_in[WR_FLAG_BIT] ? ST_WR_SHIFT : ST_HDR_SHIFT;
          end
        end
        ST_WR_SHIFT, ST_HDR_SHIFT:
        begin
          if (sclk_fall)
          begin
            if (bit_cnt == last_bit)
            begin
              sclk_en <= 1'b0;
              cs      <= 1'b1;
              mosi    <= 1'b0;
              gap_cnt <= '0;
              state   <= (state == ST_WR_SHIFT) ? ST_WR_FIN : ST_GAP;
            end
            else
            begin
              bit_cnt <= bit_cnt + 1'b1;
              mosi    <= tx_sh[CMD_BITS-2];
            end
          end
        end
        ST_WR_FIN:
        begin
          cmd_rdy <= 1'b1;
          state   <= ST_IDLE;
        end
        ST_GAP:
        begin
          if (gap_cnt == gap_cnt_t'(READ_GAP - 1))
          begin
            cs      <= 1'b0;
            sclk_en <= 1'b1;
            bit_cnt <= '0;
            state   <= ST_RD_SHIFT;
          end
          else
            gap_cnt <= gap_cnt + 1'b1;
        end
        ST_RD_SHIFT:
        begin
          if (sclk_rise)
          begin
            if (bit_cnt == bit_cnt_t'(DATA_BITS - 1))
              state <= ST_RD_FIN;
            else
              bit_cnt <= bit_cnt + 1'b1;
          end
        end
        ST_RD_FIN:
        begin
          if (sclk_fall)  // Let sclk settle low before cs rises
          begin
            sclk_en  <= 1'b0;
            cs       <= 1'b1;
            read_vld <= 1'b1;
            cmd_rdy  <= 1'b1;
            state    <= ST_IDLE;
          end
        end
        default:
          state <= ST_IDLE;
      endcase
    end
  end

  // Shift registers and read result
  always_ff @(posedge clk)
  begin
    if (accept)
      tx_sh <= cmd_in;
    else if (shifting && sclk_fall)
      tx_sh <= {tx_sh[CMD_BITS-2:0], 1'b0};

    if (state == ST_RD_SHIFT && sclk_rise)
      rx_sh <= {rx_sh[DATA_BITS-2:0], miso};

    if (state == ST_RD_FIN && sclk_fall)
      read_data <= rx_sh;
  end

endmodule

// ==== verilog/sclk_gen.sv ====
module sclk_gen
  import spi_link_pkg::*;
(
  input  logic clk,
  input  logic rst_n,
  input  logic sclk_en,
  output logic sclk,
  output logic sclk_rise,
  output logic sclk_fall
);

  div_cnt_t div_cnt;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      div_cnt   <= '0;
      sclk      <= 1'b0;
      sclk_rise <= 1'b0;
      sclk_fall <= 1'b0;
    end
    else if (!sclk_en)
    begin
      div_cnt   <= '0;    // Park low, restart on next enable
      sclk      <= 1'b0;
      sclk_rise <= 1'b0;
      sclk_fall <= 1'b0;
    end
    else
    begin
      sclk_rise <= 1'b0;
      sclk_fall <= 1'b0;
      if (div_cnt == div_cnt_t'(DIV_HALF - 1))
      begin
        div_cnt   <= '0;
        sclk      <= ~sclk;
        sclk_rise <= ~sclk;  // Strobe aligned with new level
        sclk_fall <= sclk;
      end
      else
        div_cnt <= div_cnt + 1'b1;
    end
  end

endmodule

// ==== verilog/spi_link_pkg.sv ====
package spi_link_pkg;

  localparam int NUM_REGS    = 8;
  localparam int CMD_BITS    = 12;  // Flag, address and data
  localparam int HDR_BITS    = 4;   // Flag and address only
  localparam int DIV_HALF    = 4;   // clk cycles per sclk half period
  localparam int READ_GAP    = 16;  // cs high between header and data
  localparam int WR_FLAG_BIT = 11;

  localparam int ADDR_BITS = 3;
  localparam int DATA_BITS = 8;

  // Counter widths
  localparam int BCNT_BITS = $clog2(CMD_BITS + 1);
  localparam int GAP_BITS  = $clog2(READ_GAP);
  localparam int DIV_BITS  = $clog2(DIV_HALF);

  typedef logic [CMD_BITS-1:0]           cmd_t;
  typedef logic [ADDR_BITS-1:0]          addr_t;
  typedef logic [DATA_BITS-1:0]          data_t;
  typedef logic [NUM_REGS*DATA_BITS-1:0] regs_t;  // Register 0 in low byte

  typedef logic [BCNT_BITS-1:0] bit_cnt_t;
  typedef logic [GAP_BITS-1:0]  gap_cnt_t;
  typedef logic [DIV_BITS-1:0]  div_cnt_t;

endpackage
